//--- tb.f
+incdir+include
src/tcp_engine_pkg.sv
src/mem_port_pkg.sv
src/stream_fifo.sv
src/buffer_channel.sv
src/mem_write_arbiter.sv
src/tcp_mem_frontend.sv
test/tb_tcp_mem_frontend.sv

//--- include/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// mismatches seen so far
int err_count = 0;

// one step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// compare up to a full beat, report and count a mismatch
task automatic check_value(
  input string        what,
  input logic [511:0] got,
  input logic [511:0] exp
);
  if (got !== exp) begin
    err_count++;
    $display("ERR %0t %s: got %0h expected %0h", $time, what, got, exp);
  end
endtask

`endif

//--- test/tb_tcp_mem_frontend.sv
module tb_tcp_mem_frontend;

  `include "tb_util.svh"

  localparam int stall_limit = 2000;   // cycles one engine input may wait
  localparam int drain_limit = 20000;  // cycles for the memory port to empty

  logic                                      net_clk;
  logic                                      rst;

  logic                                      rx_cmd_valid;
  logic                                      rx_cmd_ready;
  logic [tcp_engine_pkg::cmd_w-1:0]          rx_cmd_data;
  logic                                      rx_wr_valid;
  logic                                      rx_wr_ready;
  logic [tcp_engine_pkg::word_w-1:0]         rx_wr_data;
  logic [tcp_engine_pkg::keep_w-1:0]         rx_wr_keep;
  logic                                      rx_wr_last;

  logic                                      tx_cmd_valid;
  logic                                      tx_cmd_ready;
  logic [tcp_engine_pkg::cmd_w-1:0]          tx_cmd_data;
  logic                                      tx_wr_valid;
  logic                                      tx_wr_ready;
  logic [tcp_engine_pkg::word_w-1:0]         tx_wr_data;
  logic [tcp_engine_pkg::keep_w-1:0]         tx_wr_keep;
  logic                                      tx_wr_last;

  logic                                      mem_cmd_valid;
  logic                                      mem_cmd_ready;
  logic [mem_port_pkg::mem_addr_w-1:0]       mem_cmd_addr;
  logic [mem_port_pkg::mem_len_w-1:0]        mem_cmd_len;
  logic                                      mem_cmd_chan;
  logic                                      mem_data_valid;
  logic                                      mem_data_ready;
  logic [mem_port_pkg::beat_w-1:0]           mem_data;
  logic [mem_port_pkg::beat_keep_w-1:0]      mem_data_keep;
  logic                                      mem_data_last;

  // reference model keeps one queue per channel
  mem_port_pkg::mem_cmd_t  exp_cmd_rx [$];
  mem_port_pkg::mem_cmd_t  exp_cmd_tx [$];
  mem_port_pkg::mem_beat_t exp_beat_rx [$];
  mem_port_pkg::mem_beat_t exp_beat_tx [$];
  logic                    chan_log [$];   // mem_cmd_chan of every command handshake

  logic [31:0] rng_state  = 32'd92104;
  logic        locked     = 1'b0;  // a packet is open on the memory port
  logic        cur_chan   = 1'b0;
  logic        hold_cmd   = 1'b0;
  logic        rand_ready = 1'b0;
  logic        timed_out  = 1'b0;  // some wait gave up

  tcp_mem_frontend #(.cmd_depth(4), .beat_depth(4)) dut (
    .net_clk (net_clk), .rst (rst),
    .rx_cmd_valid (rx_cmd_valid), .rx_cmd_ready (rx_cmd_ready), .rx_cmd_data (rx_cmd_data),
    .rx_wr_valid (rx_wr_valid), .rx_wr_ready (rx_wr_ready), .rx_wr_data (rx_wr_data),
    .rx_wr_keep (rx_wr_keep), .rx_wr_last (rx_wr_last),
    .tx_cmd_valid (tx_cmd_valid), .tx_cmd_ready (tx_cmd_ready), .tx_cmd_data (tx_cmd_data),
    .tx_wr_valid (tx_wr_valid), .tx_wr_ready (tx_wr_ready), .tx_wr_data (tx_wr_data),
    .tx_wr_keep (tx_wr_keep), .tx_wr_last (tx_wr_last),
    .mem_cmd_valid (mem_cmd_valid), .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd_addr (mem_cmd_addr), .mem_cmd_len (mem_cmd_len), .mem_cmd_chan (mem_cmd_chan),
    .mem_data_valid (mem_data_valid), .mem_data_ready (mem_data_ready),
    .mem_data (mem_data), .mem_data_keep (mem_data_keep), .mem_data_last (mem_data_last)
  );

  initial begin
    net_clk = 1'b0;
    forever #20 net_clk = ~net_clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic chan_ready(input logic chan, input logic is_cmd);
    if (is_cmd) begin
      return chan ? tx_cmd_ready : rx_cmd_ready;
    end
    return chan ? tx_wr_ready : rx_wr_ready;
  endfunction

  task automatic set_cmd(input logic chan, input logic valid,
                         input logic [tcp_engine_pkg::cmd_w-1:0] data);
    if (chan) begin
      tx_cmd_valid = valid;
      tx_cmd_data  = data;
    end else begin
      rx_cmd_valid = valid;
      rx_cmd_data  = data;
    end
  endtask

  task automatic set_word(input logic chan, input logic valid, input logic [63:0] data,
                          input logic [7:0] keep, input logic last);
    if (chan) begin
      tx_wr_valid = valid;
      tx_wr_data  = data;
      tx_wr_keep  = keep;
      tx_wr_last  = last;
    end else begin
      rx_wr_valid = valid;
      rx_wr_data  = data;
      rx_wr_keep  = keep;
      rx_wr_last  = last;
    end
  endtask

  task automatic finish_run();
    $display("error count: %0d", err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  // holds the input until ready and returns just after the transfer edge
  task automatic wait_accept(input logic chan, input logic is_cmd);
    int waited;
    waited = 0;
    while (!timed_out && !chan_ready(chan, is_cmd) && waited < stall_limit) begin
      @(posedge net_clk);
      #2;
      waited++;
    end
    if (!timed_out && !chan_ready(chan, is_cmd)) begin
      $display("%0t: channel %0d input never became ready", $time, chan);
      err_count++;
      timed_out = 1'b1;
    end else if (!timed_out) begin
      @(posedge net_clk);
      #2;
    end
  endtask

  task automatic send_packet(input logic chan, input int nwords);
    logic [tcp_engine_pkg::cmd_w-1:0] cmd;
    logic [63:0]             wdata [20];
    logic [7:0]              wkeep [20];
    logic [31:0]             r0;
    logic [31:0]             r1;
    logic [31:0]             r2;
    mem_port_pkg::mem_cmd_t  ecmd;
    mem_port_pkg::mem_beat_t ebeat;
    int                      lane;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    cmd = {r2[7:0], r1, r0};  // spare bits random as well
    ecmd.addr = {32'b0, cmd[63:32]};
    ecmd.len  = {9'b0, cmd[22:0]};
    if (chan) exp_cmd_tx.push_back(ecmd);
    else exp_cmd_rx.push_back(ecmd);

    // expected beats fill eight lanes from the bottom
    ebeat = '0;
    lane  = 0;
    for (int i = 0; i < nwords; i++) begin
      r0 = next_rand();
      r1 = next_rand();
      r2 = next_rand();
      wdata[i] = {r1, r0};
      wkeep[i] = r2[7:0];
      ebeat.data[lane*64 +: 64] = wdata[i];
      ebeat.keep[lane*8 +: 8]   = wkeep[i];
      if (i == nwords - 1 || lane == 7) begin
        ebeat.last = (i == nwords - 1);
        if (chan) exp_beat_tx.push_back(ebeat);
        else exp_beat_rx.push_back(ebeat);
        ebeat = '0;
        lane  = 0;
      end else begin
        lane++;
      end
    end

    set_cmd(chan, 1'b1, cmd);
    wait_accept(chan, 1'b1);
    set_cmd(chan, 1'b0, '0);
    for (int i = 0; i < nwords; i++) begin
      set_word(chan, 1'b1, wdata[i], wkeep[i], i == nwords - 1);
      wait_accept(chan, 1'b0);
    end
    set_word(chan, 1'b0, '0, '0, 1'b0);
  endtask

  // first packets are one word, one full beat and the longest
  task automatic send_burst(input logic chan, input int count, input int max_words);
    int n;
    for (int i = 0; i < count; i++) begin
      case (i)
        0:       n = 1;
        1:       n = 8;
        2:       n = max_words;
        default: n = 1 + (next_rand() % max_words);
      endcase
      send_packet(chan, n);
    end
  endtask

  task automatic take_cmd();
    mem_port_pkg::mem_cmd_t e;
    chan_log.push_back(mem_cmd_chan);
    if (locked) begin
      $display("%0t: command on channel %0d while a packet was open", $time, mem_cmd_chan);
      err_count++;
    end
    if ((mem_cmd_chan ? exp_cmd_tx.size() : exp_cmd_rx.size()) == 0) begin
      $display("%0t: unexpected command on channel %0d", $time, mem_cmd_chan);
      err_count++;
    end else begin
      if (mem_cmd_chan) e = exp_cmd_tx.pop_front();
      else e = exp_cmd_rx.pop_front();
      check_value("mem_cmd_addr", mem_cmd_addr, e.addr);
      check_value("mem_cmd_len", mem_cmd_len, e.len);
    end
    locked   = 1'b1;
    cur_chan = mem_cmd_chan;
  endtask

  task automatic take_beat();
    mem_port_pkg::mem_beat_t e;
    if (!locked) begin
      $display("%0t: data beat on the memory port without a command", $time);
      err_count++;
    end else if ((cur_chan ? exp_beat_tx.size() : exp_beat_rx.size()) == 0) begin
      $display("%0t: more data beats than expected on channel %0d", $time, cur_chan);
      err_count++;
    end else begin
      if (cur_chan) e = exp_beat_tx.pop_front();
      else e = exp_beat_rx.pop_front();
      check_value("mem_data", mem_data, e.data);
      check_value("mem_data_keep", mem_data_keep, e.keep);
      check_value("mem_data_last", mem_data_last, e.last);
    end
    if (mem_data_last) locked = 1'b0;
  endtask

  function automatic logic model_empty();
    return exp_cmd_rx.size() == 0 && exp_cmd_tx.size() == 0 &&
           exp_beat_rx.size() == 0 && exp_beat_tx.size() == 0 && !locked;
  endfunction

  task automatic wait_drain(input string phase);
    int waited;
    waited = 0;
    while (!timed_out && !model_empty() && waited < drain_limit) begin
      @(posedge net_clk);
      #2;
      waited++;
    end
    if (!timed_out && !model_empty()) begin
      $display("%s: memory port still had pending packets at the timeout", phase);
      err_count++;
      timed_out = 1'b1;
    end
  endtask

  // memory side drives ready after the edge and samples handshakes mid-cycle
  initial begin
    logic [31:0] r;
    mem_cmd_ready  = 1'b0;
    mem_data_ready = 1'b0;
    forever begin
      @(posedge net_clk);
      #2;
      r = next_rand();
      mem_cmd_ready  = !hold_cmd && (!rand_ready || r[0]);
      mem_data_ready = !rand_ready || r[1];
      @(negedge net_clk);
      if (mem_cmd_valid && mem_cmd_ready) take_cmd();
      if (mem_data_valid && mem_data_ready) take_beat();
    end
  end

  initial begin
    rst = 1'b1;
    set_cmd(1'b0, 1'b0, '0);
    set_cmd(1'b1, 1'b0, '0);
    set_word(1'b0, 1'b0, '0, '0, 1'b0);
    set_word(1'b1, 1'b0, '0, '0, 1'b0);
    repeat (2) @(posedge net_clk);
    #2;
    rst = 1'b0;

    check_value("mem_cmd_valid", mem_cmd_valid, 1'b0);
    check_value("mem_data_valid", mem_data_valid, 1'b0);
    check_value("rx_cmd_ready", rx_cmd_ready, 1'b1);
    check_value("tx_cmd_ready", tx_cmd_ready, 1'b1);
    check_value("rx_wr_ready", rx_wr_ready, 1'b1);
    check_value("tx_wr_ready", tx_wr_ready, 1'b1);

    // three one-beat packets per channel queue up behind a blocked command port
    hold_cmd = 1'b1;
    chan_log.delete();
    fork
      send_burst(1'b0, 3, 8);
      send_burst(1'b1, 3, 8);
    join
    hold_cmd = 1'b0;
    wait_drain("preload");
    if (chan_log.size() != 6) begin
      $display("preload: expected 6 memory commands, saw %0d", chan_log.size());
      err_count++;
    end
    for (int i = 0; i < chan_log.size() && i < 6; i++) begin
      check_value("mem_cmd_chan", chan_log[i], i % 2);  // rx first, then alternate
    end

    // random traffic on both channels with random memory back-pressure
    rand_ready = 1'b1;
    fork
      send_burst(1'b0, 12, 20);
      send_burst(1'b1, 12, 20);
    join
    wait_drain("random traffic");
    rand_ready = 1'b0;
    check_value("mem_cmd_valid", mem_cmd_valid, 1'b0);
    check_value("mem_data_valid", mem_data_valid, 1'b0);
    finish_run();
  end

endmodule

//--- src/tcp_mem_frontend.sv
module tcp_mem_frontend #(
  parameter int cmd_depth  = 4,
  parameter int beat_depth = 4
) (
  input  logic                                    net_clk,
  input  logic                                    rst,

  // receive buffer channel
  input  logic                                    rx_cmd_valid,
  output logic                                    rx_cmd_ready,
  input  logic [tcp_engine_pkg::cmd_w-1:0]        rx_cmd_data,
  input  logic                                    rx_wr_valid,
  output logic                                    rx_wr_ready,
  input  logic [tcp_engine_pkg::word_w-1:0]       rx_wr_data,
  input  logic [tcp_engine_pkg::keep_w-1:0]       rx_wr_keep,
  input  logic                                    rx_wr_last,

  // transmit buffer channel
  input  logic                                    tx_cmd_valid,
  output logic                                    tx_cmd_ready,
  input  logic [tcp_engine_pkg::cmd_w-1:0]        tx_cmd_data,
  input  logic                                    tx_wr_valid,
  output logic                                    tx_wr_ready,
  input  logic [tcp_engine_pkg::word_w-1:0]       tx_wr_data,
  input  logic [tcp_engine_pkg::keep_w-1:0]       tx_wr_keep,
  input  logic                                    tx_wr_last,

  // shared memory write port
  output logic                                    mem_cmd_valid,
  input  logic                                    mem_cmd_ready,
  output logic [mem_port_pkg::mem_addr_w-1:0]     mem_cmd_addr,
  output logic [mem_port_pkg::mem_len_w-1:0]      mem_cmd_len,
  output logic                                    mem_cmd_chan,
  output logic                                    mem_data_valid,
  input  logic                                    mem_data_ready,
  output logic [mem_port_pkg::beat_w-1:0]         mem_data,
  output logic [mem_port_pkg::beat_keep_w-1:0]    mem_data_keep,
  output logic                                    mem_data_last
);

  logic                    rx_q_cmd_valid, rx_q_cmd_ready;
  logic                    rx_q_beat_valid, rx_q_beat_ready;
  mem_port_pkg::mem_cmd_t  rx_q_cmd;
  mem_port_pkg::mem_beat_t rx_q_beat;

  logic                    tx_q_cmd_valid, tx_q_cmd_ready;
  logic                    tx_q_beat_valid, tx_q_beat_ready;
  mem_port_pkg::mem_cmd_t  tx_q_cmd;
  mem_port_pkg::mem_beat_t tx_q_beat;

  buffer_channel #(.cmd_depth(cmd_depth), .beat_depth(beat_depth)) rx_chan (
    .net_clk (net_clk), .rst (rst),
    .cmd_valid (rx_cmd_valid), .cmd_ready (rx_cmd_ready), .cmd_data (rx_cmd_data),
    .wr_valid (rx_wr_valid), .wr_ready (rx_wr_ready), .wr_data (rx_wr_data),
    .wr_keep (rx_wr_keep), .wr_last (rx_wr_last),
    .out_cmd_valid (rx_q_cmd_valid), .out_cmd_ready (rx_q_cmd_ready), .out_cmd (rx_q_cmd),
    .out_beat_valid (rx_q_beat_valid), .out_beat_ready (rx_q_beat_ready),
    .out_beat (rx_q_beat)
  );

  buffer_channel #(.cmd_depth(cmd_depth), .beat_depth(beat_depth)) tx_chan (
    .net_clk (net_clk), .rst (rst),
    .cmd_valid (tx_cmd_valid), .cmd_ready (tx_cmd_ready), .cmd_data (tx_cmd_data),
    .wr_valid (tx_wr_valid), .wr_ready (tx_wr_ready), .wr_data (tx_wr_data),
    .wr_keep (tx_wr_keep), .wr_last (tx_wr_last),
    .out_cmd_valid (tx_q_cmd_valid), .out_cmd_ready (tx_q_cmd_ready), .out_cmd (tx_q_cmd),
    .out_beat_valid (tx_q_beat_valid), .out_beat_ready (tx_q_beat_ready),
    .out_beat (tx_q_beat)
  );

  // one packet at a time onto the memory port
  mem_write_arbiter arb (
    .net_clk (net_clk), .rst (rst),
    .rx_cmd_valid (rx_q_cmd_valid), .rx_cmd_ready (rx_q_cmd_ready), .rx_cmd (rx_q_cmd),
    .rx_beat_valid (rx_q_beat_valid), .rx_beat_ready (rx_q_beat_ready),
    .rx_beat (rx_q_beat),
    .tx_cmd_valid (tx_q_cmd_valid), .tx_cmd_ready (tx_q_cmd_ready), .tx_cmd (tx_q_cmd),
    .tx_beat_valid (tx_q_beat_valid), .tx_beat_ready (tx_q_beat_ready),
    .tx_beat (tx_q_beat),
    .mem_cmd_valid (mem_cmd_valid), .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd_addr (mem_cmd_addr), .mem_cmd_len (mem_cmd_len), .mem_cmd_chan (mem_cmd_chan),
    .mem_data_valid (mem_data_valid), .mem_data_ready (mem_data_ready),
    .mem_data (mem_data), .mem_data_keep (mem_data_keep), .mem_data_last (mem_data_last)
  );

endmodule

//--- src/mem_write_arbiter.sv
module mem_write_arbiter (
  input  logic                                    net_clk,
  input  logic                                    rst,

  input  logic                                    rx_cmd_valid,
  output logic                                    rx_cmd_ready,
  input  mem_port_pkg::mem_cmd_t                  rx_cmd,
  input  logic                                    rx_beat_valid,
  output logic                                    rx_beat_ready,
  input  mem_port_pkg::mem_beat_t                 rx_beat,

  input  logic                                    tx_cmd_valid,
  output logic                                    tx_cmd_ready,
  input  mem_port_pkg::mem_cmd_t                  tx_cmd,
  input  logic                                    tx_beat_valid,
  output logic                                    tx_beat_ready,
  input  mem_port_pkg::mem_beat_t                 tx_beat,

  output logic                                    mem_cmd_valid,
  input  logic                                    mem_cmd_ready,
  output logic [mem_port_pkg::mem_addr_w-1:0]     mem_cmd_addr,
  output logic [mem_port_pkg::mem_len_w-1:0]      mem_cmd_len,
  output logic                                    mem_cmd_chan,

  output logic                                    mem_data_valid,
  input  logic                                    mem_data_ready,
  output logic [mem_port_pkg::beat_w-1:0]         mem_data,
  output logic [mem_port_pkg::beat_keep_w-1:0]    mem_data_keep,
  output logic                                    mem_data_last
);

  typedef enum logic [1:0] {
    st_idle,
    st_cmd,
    st_data
  } state_t;

  state_t state;
  logic   grant;        // 0 rx, 1 tx
  logic   last_served;
  logic   pick;
  logic   cmd_fire;
  logic   data_fire;

  mem_port_pkg::mem_cmd_t  sel_cmd;
  mem_port_pkg::mem_beat_t sel_beat;

  // on a tie, the channel not served last wins
  assign pick = (rx_cmd_valid && tx_cmd_valid) ? ~last_served : tx_cmd_valid;

  assign sel_cmd  = grant ? tx_cmd : rx_cmd;
  assign sel_beat = grant ? tx_beat : rx_beat;

  assign mem_cmd_valid  = (state == st_cmd) && (grant ? tx_cmd_valid : rx_cmd_valid);
  assign mem_cmd_addr   = sel_cmd.addr;
  assign mem_cmd_len    = sel_cmd.len;
  assign mem_cmd_chan   = grant;

  assign mem_data_valid = (state == st_data) && (grant ? tx_beat_valid : rx_beat_valid);
  assign mem_data       = sel_beat.data;
  assign mem_data_keep  = sel_beat.keep;
  assign mem_data_last  = sel_beat.last;

  assign cmd_fire  = mem_cmd_valid && mem_cmd_ready;
  assign data_fire = mem_data_valid && mem_data_ready;

  // only the granted channel sees ready
  assign rx_cmd_ready  = (state == st_cmd) && !grant && mem_cmd_ready;
  assign tx_cmd_ready  = (state == st_cmd) && grant && mem_cmd_ready;
  assign rx_beat_ready = (state == st_data) && !grant && mem_data_ready;
  assign tx_beat_ready = (state == st_data) && grant && mem_data_ready;

  always_ff @(posedge net_clk) begin
    if (rst) begin
      state       <= st_idle;
      grant       <= 1'b0;
      last_served <= 1'b1;  // so rx goes first
    end else begin
      case (state)
        st_idle: begin
          if (rx_cmd_valid || tx_cmd_valid) begin
            grant       <= pick;
            last_served <= pick;
            state       <= st_cmd;
          end
        end
        st_cmd: begin
          if (cmd_fire) state <= st_data;
        end
        st_data: begin
          if (data_fire && sel_beat.last) state <= st_idle;  // packet done
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- src/buffer_channel.sv
module buffer_channel #(
  parameter int cmd_depth  = 4,
  parameter int beat_depth = 4
) (
  input  logic                                net_clk,
  input  logic                                rst,

  // packed write commands from the engine
  input  logic                                cmd_valid,
  output logic                                cmd_ready,
  input  logic [tcp_engine_pkg::cmd_w-1:0]    cmd_data,

  // write words from the engine
  input  logic                                wr_valid,
  output logic                                wr_ready,
  input  logic [tcp_engine_pkg::word_w-1:0]   wr_data,
  input  logic [tcp_engine_pkg::keep_w-1:0]   wr_keep,
  input  logic                                wr_last,

  // towards the arbiter
  output logic                                out_cmd_valid,
  input  logic                                out_cmd_ready,
  output mem_port_pkg::mem_cmd_t              out_cmd,

  output logic                                out_beat_valid,
  input  logic                                out_beat_ready,
  output mem_port_pkg::mem_beat_t             out_beat
);

  localparam int word_w   = tcp_engine_pkg::word_w;
  localparam int keep_w   = tcp_engine_pkg::keep_w;
  localparam int lanes    = mem_port_pkg::words_per_beat;
  localparam int lane_w   = $clog2(lanes);
  localparam logic [lane_w-1:0] last_lane = lane_w'(lanes - 1);

  mem_port_pkg::mem_cmd_t  cmd_entry;
  mem_port_pkg::mem_beat_t beat_entry;

  logic [lane_w-1:0]                    lane;      // next lane to fill
  logic [mem_port_pkg::beat_w-1:0]      acc_data;
  logic [mem_port_pkg::beat_keep_w-1:0] acc_keep;
  logic [mem_port_pkg::beat_w-1:0]      next_data;
  logic [mem_port_pkg::beat_keep_w-1:0] next_keep;
  logic                                 wr_fire;
  logic                                 word_closes;
  logic                                 beat_in_ready;

  // address is zero-extended upper half, length the low 23 bits
  assign cmd_entry.addr = mem_port_pkg::mem_addr_w'(
    cmd_data[tcp_engine_pkg::cmd_addr_msb:tcp_engine_pkg::cmd_addr_lsb]);
  assign cmd_entry.len  = mem_port_pkg::mem_len_w'(
    cmd_data[tcp_engine_pkg::cmd_len_msb:0]);

  stream_fifo #(
    .entry_t (mem_port_pkg::mem_cmd_t),
    .depth   (cmd_depth)
  ) cmd_fifo (
    .net_clk   (net_clk),
    .rst       (rst),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .in_entry  (cmd_entry),
    .out_valid (out_cmd_valid),
    .out_ready (out_cmd_ready),
    .out_entry (out_cmd)
  );

  // words stall whenever the beat queue has no room
  assign wr_ready    = beat_in_ready;
  assign wr_fire     = wr_valid && wr_ready;
  assign word_closes = wr_last || (lane == last_lane);

  // lanes below the counter come from the accumulator, lanes above are zero
  always_comb begin
    next_data = '0;
    next_keep = '0;
    for (int i = 0; i < lanes; i++) begin
      if (i < lane) begin
        next_data[i*word_w +: word_w] = acc_data[i*word_w +: word_w];
        next_keep[i*keep_w +: keep_w] = acc_keep[i*keep_w +: keep_w];
      end else if (i == lane) begin
        next_data[i*word_w +: word_w] = wr_data;
        next_keep[i*keep_w +: keep_w] = wr_keep;
      end
    end
  end

  assign beat_entry.data = next_data;
  assign beat_entry.keep = next_keep;
  assign beat_entry.last = wr_last;

  always_ff @(posedge net_clk) begin
    if (rst) begin
      lane <= '0;
    end else if (wr_fire) begin
      lane <= word_closes ? '0 : lane + 1'b1;  // restart after every beat
    end
  end

  always_ff @(posedge net_clk) begin
    if (wr_fire) begin
      acc_data <= next_data;
      acc_keep <= next_keep;
    end
  end

  stream_fifo #(
    .entry_t (mem_port_pkg::mem_beat_t),
    .depth   (beat_depth)
  ) beat_fifo (
    .net_clk   (net_clk),
    .rst       (rst),
    .in_valid  (wr_fire && word_closes),  // closing word pushes the beat
    .in_ready  (beat_in_ready),
    .in_entry  (beat_entry),
    .out_valid (out_beat_valid),
    .out_ready (out_beat_ready),
    .out_entry (out_beat)
  );

endmodule

//--- src/stream_fifo.sv
module stream_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  depth   = 4
) (
  input  logic   net_clk,
  input  logic   rst,

  input  logic   in_valid,
  output logic   in_ready,
  input  entry_t in_entry,

  output logic   out_valid,
  input  logic   out_ready,
  output entry_t out_entry
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [ptr_w-1:0] last_idx = ptr_w'(depth - 1);
  localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

  entry_t mem [depth];  // entry storage

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != full_count);
  assign out_valid = (count != '0);
  assign out_entry = mem[rd_ptr];  // head of queue

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge net_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_entry;
    end
  end

  // pointers wrap at depth, which need not be a power of two
  always_ff @(posedge net_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

//--- src/mem_port_pkg.sv
package mem_port_pkg;

  // memory write port, one beat holds eight engine words
  localparam int beat_w         = 512;
  localparam int beat_keep_w    = beat_w / 8;
  localparam int words_per_beat = 8;

  localparam int mem_addr_w = 64;  // byte address
  localparam int mem_len_w  = 32;  // byte count

  // write command after unpacking, 96 bits
  typedef struct packed {
    logic [mem_addr_w-1:0] addr;
    logic [mem_len_w-1:0]  len;
  } mem_cmd_t;

  // one memory data beat, 577 bits
  typedef struct packed {
    logic [beat_w-1:0]      data;
    logic [beat_keep_w-1:0] keep;  // zero in unused lanes
    logic                   last;  // closes the packet
  } mem_beat_t;

endpackage

//--- src/tcp_engine_pkg.sv
package tcp_engine_pkg;

  // engine word stream, one 64-bit word per handshake
  localparam int word_w = 64;
  localparam int keep_w = word_w / 8;  // one enable per byte

  // packed write command as issued by the engine
  // 71:64 spare, 63:32 buffer address, 22:0 length
  localparam int cmd_w = 72;

  localparam int cmd_addr_lsb = 32;
  localparam int cmd_addr_msb = 63;

  // length field runs from bit 0 up to here
  localparam int cmd_len_msb = 22;

endpackage
